// File: verilog/rv_isa_pkg.sv
// rv64i instruction set encodings
package rv_isa_pkg;

  // data path and field widths
  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  // major opcodes, one per instruction class
  localparam opcode_t OP_LOAD   = 7'h03;
  localparam opcode_t OP_IMM    = 7'h13;
  localparam opcode_t OP_AUIPC  = 7'h17;
  localparam opcode_t OP_IMM_32 = 7'h1b;
  localparam opcode_t OP_STORE  = 7'h23;
  localparam opcode_t OP        = 7'h33;
  localparam opcode_t OP_LUI    = 7'h37;
  localparam opcode_t OP_32     = 7'h3b;
  localparam opcode_t OP_BRANCH = 7'h63;
  localparam opcode_t OP_JALR   = 7'h67;
  localparam opcode_t OP_JAL    = 7'h6f;

  // funct7 splits add/sub and srl/sra
  localparam logic [6:0] F7_BASE = 7'h00;
  localparam logic [6:0] F7_ALT  = 7'h20;

  // funct6 splits the shift-immediate forms
  localparam logic [5:0] F6_BASE = 6'h00;
  localparam logic [5:0] F6_ALT  = 6'h10;

  // return address step for jal and jalr
  localparam xlen_t JAL_LINK_OFFSET = 64'd4;

endpackage

// File: verilog/decode_pkg.sv
// decode stage internal types
package decode_pkg;

  // one-hot alu operation
  typedef logic [9:0] alu_code_t;
  localparam int ALU_ADD  = 0;
  localparam int ALU_SUB  = 1;
  localparam int ALU_SLT  = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_XOR  = 4;
  localparam int ALU_OR   = 5;
  localparam int ALU_AND  = 6;
  localparam int ALU_SLL  = 7;
  localparam int ALU_SRL  = 8;
  localparam int ALU_SRA  = 9;

  // one-hot branch and jump kind
  typedef logic [7:0] bj_code_t;
  localparam int BJ_BEQ  = 0;
  localparam int BJ_BNE  = 1;
  localparam int BJ_BLT  = 2;
  localparam int BJ_BGE  = 3;
  localparam int BJ_BLTU = 4;
  localparam int BJ_BGEU = 5;
  localparam int BJ_JALR = 6;
  localparam int BJ_JAL  = 7;

  // lb lh lw ld lbu lhu lwu, lsb first
  typedef logic [6:0] load_code_t;
  // sb sh sw sd, lsb first
  typedef logic [3:0] store_code_t;

  typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_fmt_t;
  typedef enum logic [1:0] {OP1_ZERO, OP1_RS1, OP1_PC} op1_sel_t;
  typedef enum logic [1:0] {OP2_ZERO, OP2_RS2, OP2_IMM, OP2_LINK} op2_sel_t;
  typedef enum logic [1:0] {RD_NONE, RD_EXE, RD_MEM} rd_src_t;

  // pipeline register occupancy
  typedef enum logic {ST_EMPTY, ST_FULL} stage_state_t;

endpackage

// File: verilog/id_pipe_reg.sv
// decode stage pipeline register
module id_pipe_reg (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  rv_isa_pkg::xlen_t  in_pc,
  input  rv_isa_pkg::inst_t  in_inst,
  input  logic               ex_allowin,
  input  logic               flush,
  output logic               allowin,
  output logic               out_valid,
  output logic               held,
  output rv_isa_pkg::xlen_t  held_pc,
  output rv_isa_pkg::inst_t  held_inst
);

  decode_pkg::stage_state_t state;
  decode_pkg::stage_state_t state_nxt;
  rv_isa_pkg::xlen_t        pc_q;
  rv_isa_pkg::inst_t        inst_q;

  assign held      = (state == decode_pkg::ST_FULL);
  assign allowin   = (state == decode_pkg::ST_EMPTY) || ex_allowin;
  // a taken branch kills the held item right away
  assign out_valid = held && !flush;

  always_comb begin
    state_nxt = state;
    if (allowin) begin
      state_nxt = in_valid ? decode_pkg::ST_FULL : decode_pkg::ST_EMPTY;
    end else if (flush) begin
      state_nxt = decode_pkg::ST_EMPTY;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= decode_pkg::ST_EMPTY;
    end else begin
      state <= state_nxt;
    end
  end

  // capture on transfer
  always_ff @(posedge clk) begin
    if (in_valid && allowin) begin
      pc_q   <= in_pc;
      inst_q <= in_inst;
    end
  end

  assign held_pc   = pc_q;
  // empty stage decodes as an all-zero word
  assign held_inst = held ? inst_q : '0;

endmodule

// File: verilog/inst_classifier.sv
// rv64i instruction classifier
module inst_classifier (
  input  rv_isa_pkg::inst_t        inst,
  output decode_pkg::alu_code_t    alu_code,
  output decode_pkg::bj_code_t     bj_code,
  output decode_pkg::load_code_t   load_code,
  output decode_pkg::store_code_t  store_code,
  output logic                     is_word,
  output decode_pkg::imm_fmt_t     imm_fmt,
  output decode_pkg::op1_sel_t     op1_sel,
  output decode_pkg::op2_sel_t     op2_sel,
  output logic                     rs1_ren,
  output logic                     rs2_ren,
  output logic                     rd_wen,
  output decode_pkg::rd_src_t      rd_src,
  output logic                     illegal
);

  rv_isa_pkg::opcode_t opc;
  rv_isa_pkg::funct3_t f3;
  logic [5:0] f6;
  logic [6:0] f7;
  assign opc = inst[6:0];
  assign f3  = inst[14:12];
  assign f6  = inst[31:26];
  assign f7  = inst[31:25];

  logic c_load, c_imm, c_auipc, c_imm_w, c_store, c_op, c_lui, c_op_w, c_br, c_jalr, c_jal;
  assign c_load  = (opc == rv_isa_pkg::OP_LOAD);
  assign c_imm   = (opc == rv_isa_pkg::OP_IMM);
  assign c_auipc = (opc == rv_isa_pkg::OP_AUIPC);
  assign c_imm_w = (opc == rv_isa_pkg::OP_IMM_32);
  assign c_store = (opc == rv_isa_pkg::OP_STORE);
  assign c_op    = (opc == rv_isa_pkg::OP);
  assign c_lui   = (opc == rv_isa_pkg::OP_LUI);
  assign c_op_w  = (opc == rv_isa_pkg::OP_32);
  assign c_br    = (opc == rv_isa_pkg::OP_BRANCH);
  assign c_jalr  = (opc == rv_isa_pkg::OP_JALR) && (f3 == 3'd0);
  assign c_jal   = (opc == rv_isa_pkg::OP_JAL);

  logic f7_b, f7_a, f6_b, f6_a;
  assign f7_b = (f7 == rv_isa_pkg::F7_BASE);
  assign f7_a = (f7 == rv_isa_pkg::F7_ALT);
  assign f6_b = (f6 == rv_isa_pkg::F6_BASE);
  assign f6_a = (f6 == rv_isa_pkg::F6_ALT);

  // per-instruction matches, grouped by alu function
  logic i_add, i_sub, i_sll, i_slt, i_sltu, i_xor, i_srl, i_sra, i_or, i_and;
  assign i_add  = (c_op | c_op_w) & (f3 == 3'd0) & f7_b | (c_imm | c_imm_w) & (f3 == 3'd0);
  assign i_sub  = (c_op | c_op_w) & (f3 == 3'd0) & f7_a;
  assign i_sll  = (c_op | c_op_w) & (f3 == 3'd1) & f7_b | (c_imm | c_imm_w) & (f3 == 3'd1) & f6_b;
  assign i_slt  = (c_op | c_imm) & (f3 == 3'd2) & (c_imm | f7_b);
  assign i_sltu = (c_op | c_imm) & (f3 == 3'd3) & (c_imm | f7_b);
  assign i_xor  = (c_op | c_imm) & (f3 == 3'd4) & (c_imm | f7_b);
  assign i_srl  = (c_op | c_op_w) & (f3 == 3'd5) & f7_b | (c_imm | c_imm_w) & (f3 == 3'd5) & f6_b;
  assign i_sra  = (c_op | c_op_w) & (f3 == 3'd5) & f7_a | (c_imm | c_imm_w) & (f3 == 3'd5) & f6_a;
  assign i_or   = (c_op | c_imm) & (f3 == 3'd6) & (c_imm | f7_b);
  assign i_and  = (c_op | c_imm) & (f3 == 3'd7) & (c_imm | f7_b);

  for (genvar i = 0; i < 7; i++) begin : g_load
    assign load_code[i] = c_load & (f3 == i[2:0]);
  end
  for (genvar i = 0; i < 4; i++) begin : g_store
    assign store_code[i] = c_store & (f3 == i[2:0]);
  end

  assign bj_code[decode_pkg::BJ_BEQ]  = c_br & (f3 == 3'd0);
  assign bj_code[decode_pkg::BJ_BNE]  = c_br & (f3 == 3'd1);
  assign bj_code[decode_pkg::BJ_BLT]  = c_br & (f3 == 3'd4);
  assign bj_code[decode_pkg::BJ_BGE]  = c_br & (f3 == 3'd5);
  assign bj_code[decode_pkg::BJ_BLTU] = c_br & (f3 == 3'd6);
  assign bj_code[decode_pkg::BJ_BGEU] = c_br & (f3 == 3'd7);
  assign bj_code[decode_pkg::BJ_JALR] = c_jalr;
  assign bj_code[decode_pkg::BJ_JAL]  = c_jal;

  logic ld_v, st_v, br_v, alu_v, legal;
  assign ld_v  = |load_code;
  assign st_v  = |store_code;
  assign br_v  = |bj_code[decode_pkg::BJ_BGEU:decode_pkg::BJ_BEQ];
  assign alu_v = i_add | i_sub | i_sll | i_slt | i_sltu | i_xor | i_srl | i_sra | i_or | i_and;
  assign legal = ld_v | st_v | br_v | alu_v | c_lui | c_auipc | c_jalr | c_jal;

  // memory, upper and jump classes also go through the adder
  assign alu_code[decode_pkg::ALU_ADD]  = i_add | ld_v | st_v | c_lui | c_auipc | c_jal | c_jalr;
  assign alu_code[decode_pkg::ALU_SUB]  = i_sub | br_v;
  assign alu_code[decode_pkg::ALU_SLT]  = i_slt | bj_code[decode_pkg::BJ_BLT] | bj_code[decode_pkg::BJ_BGE];
  assign alu_code[decode_pkg::ALU_SLTU] = i_sltu | bj_code[decode_pkg::BJ_BLTU] | bj_code[decode_pkg::BJ_BGEU];
  assign alu_code[decode_pkg::ALU_XOR]  = i_xor | bj_code[decode_pkg::BJ_BEQ] | bj_code[decode_pkg::BJ_BNE];
  assign alu_code[decode_pkg::ALU_OR]   = i_or;
  assign alu_code[decode_pkg::ALU_AND]  = i_and;
  assign alu_code[decode_pkg::ALU_SLL]  = i_sll;
  assign alu_code[decode_pkg::ALU_SRL]  = i_srl;
  assign alu_code[decode_pkg::ALU_SRA]  = i_sra;

  assign is_word = alu_v & (c_op_w | c_imm_w);
  assign rs1_ren = ld_v | st_v | br_v | alu_v | c_jalr;
  assign rs2_ren = st_v | br_v | alu_v & (c_op | c_op_w);
  assign rd_wen  = ld_v | alu_v | c_lui | c_auipc | c_jal | c_jalr;
  assign rd_src  = ld_v ? decode_pkg::RD_MEM : (rd_wen ? decode_pkg::RD_EXE : decode_pkg::RD_NONE);
  assign illegal = (|inst) & ~legal;

  always_comb begin
    imm_fmt = decode_pkg::IMM_NONE;
    op1_sel = decode_pkg::OP1_ZERO;
    op2_sel = decode_pkg::OP2_ZERO;
    if (ld_v || st_v || alu_v) begin
      imm_fmt = st_v ? decode_pkg::IMM_S : decode_pkg::IMM_I;
      op1_sel = decode_pkg::OP1_RS1;
      op2_sel = (c_op || c_op_w) ? decode_pkg::OP2_RS2 : decode_pkg::OP2_IMM;
    end else if (br_v) begin
      imm_fmt = decode_pkg::IMM_B;
      op1_sel = decode_pkg::OP1_RS1;
      op2_sel = decode_pkg::OP2_RS2;
    end else if (c_lui || c_auipc) begin
      imm_fmt = decode_pkg::IMM_U;
      op1_sel = c_auipc ? decode_pkg::OP1_PC : decode_pkg::OP1_ZERO;
      op2_sel = decode_pkg::OP2_IMM;
    end else if (c_jal || c_jalr) begin
      // jalr target offset still comes from the i field
      imm_fmt = c_jal ? decode_pkg::IMM_J : decode_pkg::IMM_I;
      op1_sel = decode_pkg::OP1_PC;
      op2_sel = decode_pkg::OP2_LINK;
    end
  end

endmodule

// File: verilog/imm_gen.sv
// immediate generator
module imm_gen (
  input  rv_isa_pkg::inst_t     inst,
  input  decode_pkg::imm_fmt_t  imm_fmt,
  output rv_isa_pkg::xlen_t     imm,
  output rv_isa_pkg::xlen_t     jmp_imm
);

  rv_isa_pkg::xlen_t imm_i, imm_s, imm_b, imm_u, imm_j;

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // operand path immediate
  always_comb begin
    case (imm_fmt)
      decode_pkg::IMM_I: imm = imm_i;
      decode_pkg::IMM_S: imm = imm_s;
      decode_pkg::IMM_U: imm = imm_u;
      default:           imm = '0;
    endcase
  end

  // target offset, only jalr among the i-format users
  always_comb begin
    case (imm_fmt)
      decode_pkg::IMM_B: jmp_imm = imm_b;
      decode_pkg::IMM_J: jmp_imm = imm_j;
      decode_pkg::IMM_I: jmp_imm = (inst[6:0] == rv_isa_pkg::OP_JALR) ? imm_i : '0;
      default:           jmp_imm = '0;
    endcase
  end

endmodule

// File: verilog/operand_mux.sv
// alu operand select
module operand_mux (
  input  decode_pkg::op1_sel_t  op1_sel,
  input  decode_pkg::op2_sel_t  op2_sel,
  input  rv_isa_pkg::xlen_t     rs1_data,
  input  rv_isa_pkg::xlen_t     rs2_data,
  input  rv_isa_pkg::xlen_t     pc,
  input  rv_isa_pkg::xlen_t     imm,
  output rv_isa_pkg::xlen_t     op1,
  output rv_isa_pkg::xlen_t     op2
);

  always_comb begin
    case (op1_sel)
      decode_pkg::OP1_RS1: op1 = rs1_data;
      decode_pkg::OP1_PC:  op1 = pc;
      default:             op1 = '0;
    endcase
  end

  // link forms add the return step to pc
  always_comb begin
    case (op2_sel)
      decode_pkg::OP2_RS2:  op2 = rs2_data;
      decode_pkg::OP2_IMM:  op2 = imm;
      decode_pkg::OP2_LINK: op2 = rv_isa_pkg::JAL_LINK_OFFSET;
      default:              op2 = '0;
    endcase
  end

endmodule

// File: verilog/id_stage.sv
// rv64i instruction decode stage
module id_stage (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     in_valid,
  input  rv_isa_pkg::xlen_t        in_pc,
  input  rv_isa_pkg::inst_t        in_inst,
  output logic                     allowin,
  output logic                     out_valid,
  output rv_isa_pkg::xlen_t        out_pc,
  input  logic                     ex_allowin,
  input  logic                     flush,
  output rv_isa_pkg::reg_addr_t    rs1_addr,
  output rv_isa_pkg::reg_addr_t    rs2_addr,
  output logic                     rs1_ren,
  output logic                     rs2_ren,
  input  rv_isa_pkg::xlen_t        rs1_data,
  input  rv_isa_pkg::xlen_t        rs2_data,
  output rv_isa_pkg::xlen_t        op1,
  output rv_isa_pkg::xlen_t        op2,
  output rv_isa_pkg::xlen_t        jmp_imm,
  output decode_pkg::alu_code_t    alu_code,
  output decode_pkg::bj_code_t     bj_code,
  output decode_pkg::load_code_t   load_code,
  output decode_pkg::store_code_t  store_code,
  output logic                     is_word,
  output logic                     rd_wen,
  output rv_isa_pkg::reg_addr_t    rd_addr,
  output decode_pkg::rd_src_t      rd_src,
  output logic                     illegal
);

  logic                  held, rs1_use, rs2_use;
  rv_isa_pkg::inst_t     held_inst;
  rv_isa_pkg::xlen_t     imm;
  decode_pkg::imm_fmt_t  imm_fmt;
  decode_pkg::op1_sel_t  op1_sel;
  decode_pkg::op2_sel_t  op2_sel;

  id_pipe_reg u_pipe (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_pc(in_pc), .in_inst(in_inst),
    .ex_allowin(ex_allowin), .flush(flush), .allowin(allowin), .out_valid(out_valid),
    .held(held), .held_pc(out_pc), .held_inst(held_inst)
  );

  inst_classifier u_cls (
    .inst(held_inst), .alu_code(alu_code), .bj_code(bj_code), .load_code(load_code),
    .store_code(store_code), .is_word(is_word), .imm_fmt(imm_fmt), .op1_sel(op1_sel),
    .op2_sel(op2_sel), .rs1_ren(rs1_use), .rs2_ren(rs2_use), .rd_wen(rd_wen),
    .rd_src(rd_src), .illegal(illegal)
  );

  imm_gen u_imm (.inst(held_inst), .imm_fmt(imm_fmt), .imm(imm), .jmp_imm(jmp_imm));

  operand_mux u_opmux (
    .op1_sel(op1_sel), .op2_sel(op2_sel), .rs1_data(rs1_data), .rs2_data(rs2_data),
    .pc(out_pc), .imm(imm), .op1(op1), .op2(op2)
  );

  // no register file traffic while empty
  assign rs1_ren  = held & rs1_use;
  assign rs2_ren  = held & rs2_use;
  assign rs1_addr = rs1_ren ? held_inst[19:15] : '0;
  assign rs2_addr = rs2_ren ? held_inst[24:20] : '0;
  assign rd_addr  = rd_wen ? held_inst[11:7] : '0;

endmodule

// File: sim/id_stage_assertions.sv
// decode stage handshake checks
module id_stage_assertions (
  input logic                   clk,
  input logic                   rst,
  input logic                   allowin,
  input logic                   out_valid,
  input logic                   ex_allowin,
  input logic                   flush,
  input rv_isa_pkg::xlen_t      out_pc,
  input decode_pkg::alu_code_t  alu_code
);

  int fail_count = 0;

  // a stalled item stays put until taken or flushed
  a_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid && !ex_allowin && !flush
    |=> flush || out_valid && $stable(out_pc) && $stable(alu_code))
    else begin
      $error("held item changed or vanished while stalled");
      fail_count++;
    end

  a_flush_kills: assert property (@(posedge clk) disable iff (rst) out_valid |-> !flush)
    else begin
      $error("out_valid high while flush is asserted");
      fail_count++;
    end

  a_reset_allowin: assert property (@(posedge clk) $fell(rst) |-> allowin)
    else begin
      $error("allowin low in the cycle after reset");
      fail_count++;
    end

endmodule

bind id_stage id_stage_assertions u_checks (
  .clk(clk), .rst(rst), .allowin(allowin), .out_valid(out_valid), .ex_allowin(ex_allowin),
  .flush(flush), .out_pc(out_pc), .alu_code(alu_code)
);

// File: sim/id_stage_tb.sv
// decode stage testbench
module id_stage_tb;

  localparam rv_isa_pkg::xlen_t rs1_val = 64'h1111_2222_3333_4444;
  localparam rv_isa_pkg::xlen_t rs2_val = 64'h5555_6666_7777_8888;
  localparam rv_isa_pkg::xlen_t pc0 = 64'h8000_0100;
  // generous bound on the cycles of all tests together
  localparam int test_cycles = 200;

  logic clk, rst, in_valid, ex_allowin, flush, allowin, out_valid;
  logic rs1_ren, rs2_ren, is_word, rd_wen, illegal;
  rv_isa_pkg::xlen_t in_pc, out_pc, op1, op2, jmp_imm;
  rv_isa_pkg::inst_t in_inst;
  rv_isa_pkg::reg_addr_t rs1_addr, rs2_addr, rd_addr;
  decode_pkg::alu_code_t alu_code;
  decode_pkg::bj_code_t bj_code;
  decode_pkg::load_code_t load_code;
  decode_pkg::store_code_t store_code;
  decode_pkg::rd_src_t rd_src;
  int checks, errors;

  // register file reads return fixed patterns
  id_stage dut (.rs1_data(rs1_val), .rs2_data(rs2_val), .*);

  initial begin
    clk = 0;
    forever #4 clk = ~clk;
  end

  function automatic rv_isa_pkg::xlen_t sign_ext(input int v);
    return rv_isa_pkg::xlen_t'(longint'(v));
  endfunction

  // rs1 is x1, rs2 is x2, rd is x7
  // r forms carry funct7 and rs2 in the i immediate field
  function automatic logic [31:0] enc_i(input int imm, f3, input logic [6:0] opc);
    return {imm[11:0], 5'd1, 3'(f3), 5'd7, opc};
  endfunction
  function automatic logic [31:0] enc_s(input int off, f3);
    return {off[11:5], 5'd2, 5'd1, 3'(f3), off[4:0], rv_isa_pkg::OP_STORE};
  endfunction
  function automatic logic [31:0] enc_b(input int off, f3);
    return {off[12], off[10:5], 5'd2, 5'd1, 3'(f3), off[4:1], off[11], rv_isa_pkg::OP_BRANCH};
  endfunction
  function automatic logic [31:0] enc_j(input int off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd7, rv_isa_pkg::OP_JAL};
  endfunction

  task automatic expect_eq(input rv_isa_pkg::xlen_t got, exp, input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic step;
    @(posedge clk);
    #1;
  endtask

  // offer one instruction, return with it held and settled
  task automatic present(input rv_isa_pkg::xlen_t pc, input rv_isa_pkg::inst_t inst);
    step;
    in_valid = 1;
    in_pc = pc;
    in_inst = inst;
    #1;
    while (!allowin) begin
      step;
      #1;
    end
    step;
    in_valid = 0;
    #1;
    expect_eq(out_valid, 1, "out_valid");
    expect_eq(out_pc, pc, "out_pc");
  endtask

  task automatic check_alu(input rv_isa_pkg::inst_t inst, input int alu_bit, input logic word,
                           input rv_isa_pkg::xlen_t exp_op2);
    present(pc0, inst);
    expect_eq(alu_code, 64'd1 << alu_bit, "alu_code");
    expect_eq(is_word, word, "is_word");
    expect_eq(op1, rs1_val, "op1");
    expect_eq(op2, exp_op2, "op2");
    expect_eq({rd_wen, rs1_addr, rd_addr}, {1'b1, 5'd1, 5'd7}, "rd_wen, rs1_addr, rd_addr");
    expect_eq(rd_src, decode_pkg::RD_EXE, "rd_src");
  endtask

  task automatic test_reset;
    int err0;
    err0 = errors;
    #1;
    expect_eq({out_valid, allowin, rd_wen, illegal}, 4'b0100, "reset outputs");
    $display("test reset done, %0d errors", errors - err0);
  endtask

  task automatic test_arith;
    int err0;
    err0 = errors;
    check_alu(enc_i({rv_isa_pkg::F7_BASE, 5'd2}, 0, rv_isa_pkg::OP), decode_pkg::ALU_ADD, 0,
              rs2_val);
    check_alu(enc_i({rv_isa_pkg::F7_ALT, 5'd2}, 0, rv_isa_pkg::OP), decode_pkg::ALU_SUB, 0,
              rs2_val);
    check_alu(enc_i({rv_isa_pkg::F7_ALT, 5'd2}, 5, rv_isa_pkg::OP), decode_pkg::ALU_SRA, 0,
              rs2_val);
    check_alu(enc_i(-5, 0, rv_isa_pkg::OP_IMM), decode_pkg::ALU_ADD, 0, sign_ext(-5));
    // srai by 33 keeps funct6 above the shift amount
    check_alu(enc_i({rv_isa_pkg::F6_ALT, 6'd33}, 5, rv_isa_pkg::OP_IMM), decode_pkg::ALU_SRA, 0,
              64'h421);
    check_alu(enc_i({rv_isa_pkg::F7_BASE, 5'd2}, 0, rv_isa_pkg::OP_32), decode_pkg::ALU_ADD, 1,
              rs2_val);
    check_alu(enc_i({rv_isa_pkg::F6_ALT, 6'd3}, 5, rv_isa_pkg::OP_IMM_32), decode_pkg::ALU_SRA, 1,
              64'h403);
    $display("test arith done, %0d errors", errors - err0);
  endtask

  task automatic test_upper_jump;
    int err0;
    err0 = errors;
    present(pc0, {20'hfedcb, 5'd7, rv_isa_pkg::OP_LUI});
    expect_eq(op1, 0, "lui op1");
    expect_eq(op2, sign_ext(32'hfedc_b000), "lui op2");
    present(pc0 + 4, {20'h00012, 5'd7, rv_isa_pkg::OP_AUIPC});
    expect_eq(op1, pc0 + 4, "auipc op1");
    expect_eq(op2, 64'h12000, "auipc op2");
    present(pc0 + 8, enc_j(-4660));
    expect_eq(op1, pc0 + 8, "jal op1");
    expect_eq(op2, 64'd4, "jal op2");
    expect_eq(jmp_imm, sign_ext(-4660), "jal jmp_imm");
    expect_eq(bj_code, 64'd1 << decode_pkg::BJ_JAL, "jal bj_code");
    present(pc0 + 12, enc_i(-16, 0, rv_isa_pkg::OP_JALR));
    expect_eq(op1, pc0 + 12, "jalr op1");
    expect_eq(op2, 64'd4, "jalr op2");
    expect_eq(jmp_imm, sign_ext(-16), "jalr jmp_imm");
    expect_eq(bj_code, 64'd1 << decode_pkg::BJ_JALR, "jalr bj_code");
    $display("test upper_jump done, %0d errors", errors - err0);
  endtask

  task automatic test_mem_branch;
    int err0;
    int f3s[6] = '{0, 1, 4, 5, 6, 7};
    int bj_bits[6] = '{decode_pkg::BJ_BEQ, decode_pkg::BJ_BNE, decode_pkg::BJ_BLT,
                       decode_pkg::BJ_BGE, decode_pkg::BJ_BLTU, decode_pkg::BJ_BGEU};
    int groups[6] = '{decode_pkg::ALU_XOR, decode_pkg::ALU_XOR, decode_pkg::ALU_SLT,
                      decode_pkg::ALU_SLT, decode_pkg::ALU_SLTU, decode_pkg::ALU_SLTU};
    err0 = errors;
    for (int f3 = 0; f3 < 7; f3++) begin
      present(pc0, enc_i(100, f3, rv_isa_pkg::OP_LOAD));
      expect_eq(load_code, 64'd1 << f3, "load_code");
      expect_eq(rd_src, decode_pkg::RD_MEM, "load rd_src");
    end
    for (int f3 = 0; f3 < 4; f3++) begin
      present(pc0, enc_s(-24, f3));
      expect_eq(store_code, 64'd1 << f3, "store_code");
      expect_eq(op2, sign_ext(-24), "store op2");
      expect_eq({rs2_ren, rd_wen}, 2'b10, "store rs2_ren, rd_wen");
      expect_eq(rs2_addr, 5'd2, "store rs2_addr");
    end
    for (int i = 0; i < 6; i++) begin
      present(pc0, enc_b(-1000, f3s[i]));
      expect_eq(bj_code, 64'd1 << bj_bits[i], "branch bj_code");
      expect_eq(alu_code, (64'd1 << decode_pkg::ALU_SUB) | (64'd1 << groups[i]),
                "branch alu_code");
      expect_eq(jmp_imm, sign_ext(-1000), "branch jmp_imm");
      expect_eq(rd_wen, 0, "branch rd_wen");
    end
    $display("test mem_branch done, %0d errors", errors - err0);
  endtask

  task automatic test_backpressure;
    int err0, sent, taken, imm;
    logic full;
    rv_isa_pkg::xlen_t exp_pc[$];
    rv_isa_pkg::xlen_t exp_op2[$];
    err0 = errors;
    sent = 0;
    taken = 0;
    full = 0;
    imm = int'($urandom % 4096) - 2048;
    while (taken < 20) begin
      step;
      ex_allowin = ($urandom % 3) != 0;
      in_valid = (sent < 20);
      in_pc = pc0 + 64'(4 * sent);
      in_inst = enc_i(imm, 0, rv_isa_pkg::OP_IMM);
      #1;
      expect_eq(out_valid, full, "stream out_valid");
      expect_eq(allowin, !full || ex_allowin, "stream allowin");
      if (out_valid && ex_allowin) begin
        expect_eq(exp_pc.size() > 0, 1, "stream item accepted before delivery");
        if (exp_pc.size() > 0) begin
          expect_eq(out_pc, exp_pc.pop_front(), "stream out_pc");
          expect_eq(op2, exp_op2.pop_front(), "stream op2");
        end
        taken++;
      end
      if (in_valid && allowin) begin
        exp_pc.push_back(in_pc);
        exp_op2.push_back(sign_ext(imm));
        sent++;
        imm = int'($urandom % 4096) - 2048;
      end
      full = allowin ? in_valid : full;
    end
    step;
    in_valid = 0;
    ex_allowin = 1;
    #1;
    expect_eq(out_valid, 0, "stream drained");
    $display("test backpressure done, %0d errors", errors - err0);
  endtask

  task automatic test_flush_illegal;
    int err0;
    err0 = errors;
    step;
    ex_allowin = 0;
    present(pc0 + 16, enc_i(1, 0, rv_isa_pkg::OP_IMM));
    step;
    flush = 1;
    #1;
    expect_eq({out_valid, allowin}, 2'b00, "out_valid, allowin under flush");
    step;
    flush = 0;
    ex_allowin = 1;
    #1;
    expect_eq(out_valid, 0, "out_valid after flush");
    present(pc0 + 20, 32'h1234_507f);
    expect_eq(illegal, 1, "illegal");
    expect_eq({rs1_ren, rs2_ren, rd_wen}, 0, "enables on illegal");
    expect_eq(alu_code | bj_code | load_code | store_code, 0, "codes on illegal");
    $display("test flush_illegal done, %0d errors", errors - err0);
  endtask

  initial begin
    repeat (2 * test_cycles) @(posedge clk);
    $display("timeout: run still busy after %0d cycles", 2 * test_cycles);
    $display("Checks failed");
    $finish;
  end

  initial begin
    void'($urandom(32'hc50));
    checks = 0;
    errors = 0;
    rst = 1;
    in_valid = 0;
    in_pc = '0;
    in_inst = '0;
    ex_allowin = 1;
    flush = 0;
    repeat (3) @(posedge clk);
    #1;
    rst = 0;
    test_reset;
    test_arith;
    test_upper_jump;
    test_mem_branch;
    test_backpressure;
    test_flush_illegal;
    // bound handshake checks count toward the total
    errors += dut.u_checks.fail_count;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// File: id_stage.f
verilog/rv_isa_pkg.sv
verilog/decode_pkg.sv
verilog/id_pipe_reg.sv
verilog/inst_classifier.sv
verilog/imm_gen.sv
verilog/operand_mux.sv
verilog/id_stage.sv
sim/id_stage_assertions.sv
sim/id_stage_tb.sv
